// File: dbg_mam_pkg.sv
//////////////////////////////////////////////////////////////////////
// Single word AHB-Lite only; bursts, protection and sub-word sizes
// are not carried anywhere in the subsystem
//////////////////////////////////////////////////////////////////////

package dbg_mam_pkg;

  //////////////////////////////////////////////////////////////////////
  // Bus and memory sizes
  //////////////////////////////////////////////////////////////////////

  // Address width
  localparam int PLEN = 32;
  // Data width
  localparam int XLEN = 32;
  // RAM word index width, 256 words
  localparam int MEM_AW = 8;

  //////////////////////////////////////////////////////////////////////
  // AHB encodings
  //////////////////////////////////////////////////////////////////////

  localparam logic [1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;

  // 32-bit transfer size, the only one the RAM takes
  localparam logic [2:0] HSIZE_WORD = 3'b010;

  //////////////////////////////////////////////////////////////////////
  // State and opcode types
  //////////////////////////////////////////////////////////////////////

  // Arbiter owner of the memory port
  typedef enum logic [1:0] {
    ARB_IDLE       = 2'd0,
    ARB_ACCESS_MAM = 2'd1,
    ARB_ACCESS_CPU = 2'd2
  } arb_state_e;

  // Debug command opcodes
  typedef enum logic {
    MAM_OP_READ  = 1'b0,
    MAM_OP_WRITE = 1'b1
  } mam_op_e;

  // MAM bus engine sequence
  typedef enum logic [2:0] {
    MAM_IDLE    = 3'd0,
    MAM_LOCK    = 3'd1,
    MAM_ADDR    = 3'd2,
    MAM_DATA    = 3'd3,
    MAM_RELEASE = 3'd4
  } mam_state_e;

endpackage

// File: dbg_mam_ahb_arbiter.sv
//////////////////////////////////////////////////////////////////////
// Masters must hold hmastlock around their transfers; the grant takes
// two cycles from idle and a locked CPU is never preempted
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dbg_mam_ahb_arbiter (
  input  logic                          biu_in_clk_i,
  input  logic                          biu_in_rst_i,

  // CPU master side
  input  logic                          biu_in_hsel_i,
  input  logic [dbg_mam_pkg::PLEN-1:0]  biu_in_haddr_i,
  input  logic [dbg_mam_pkg::XLEN-1:0]  biu_in_hwdata_i,
  input  logic                          biu_in_hwrite_i,
  input  logic [2:0]                    biu_in_hsize_i,
  input  logic [1:0]                    biu_in_htrans_i,
  input  logic                          biu_in_hmastlock_i,
  output logic [dbg_mam_pkg::XLEN-1:0]  biu_in_hrdata_o,
  output logic                          biu_in_hready_o,
  output logic                          biu_in_hresp_o,

  // MAM master side
  input  logic                          biu_mam_hsel_i,
  input  logic [dbg_mam_pkg::PLEN-1:0]  biu_mam_haddr_i,
  input  logic [dbg_mam_pkg::XLEN-1:0]  biu_mam_hwdata_i,
  input  logic                          biu_mam_hwrite_i,
  input  logic [2:0]                    biu_mam_hsize_i,
  input  logic [1:0]                    biu_mam_htrans_i,
  input  logic                          biu_mam_hmastlock_i,
  output logic [dbg_mam_pkg::XLEN-1:0]  biu_mam_hrdata_o,
  output logic                          biu_mam_hready_o,
  output logic                          biu_mam_hresp_o,

  // Memory side
  output logic                          biu_out_hsel_o,
  output logic [dbg_mam_pkg::PLEN-1:0]  biu_out_haddr_o,
  output logic [dbg_mam_pkg::XLEN-1:0]  biu_out_hwdata_o,
  output logic                          biu_out_hwrite_o,
  output logic [2:0]                    biu_out_hsize_o,
  output logic [1:0]                    biu_out_htrans_o,
  output logic                          biu_out_hmastlock_o,
  input  logic [dbg_mam_pkg::XLEN-1:0]  biu_out_hrdata_i,
  input  logic                          biu_out_hready_i,
  input  logic                          biu_out_hresp_i
);

  dbg_mam_pkg::arb_state_e state_q;
  dbg_mam_pkg::arb_state_e state_d;

  // Registered grant, 1 selects the CPU
  logic access_cpu;

  //////////////////////////////////////////////////////////////////////
  // Arbitration FSM
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge biu_in_clk_i) begin
    if (biu_in_rst_i) begin
      state_q    <= dbg_mam_pkg::ARB_IDLE;
      access_cpu <= 1'b0;
    end else begin
      state_q <= state_d;
      // Grant follows the state one cycle later, holds its value in idle
      if (state_q == dbg_mam_pkg::ARB_ACCESS_CPU) begin
        access_cpu <= 1'b1;
      end else if (state_q == dbg_mam_pkg::ARB_ACCESS_MAM) begin
        access_cpu <= 1'b0;
      end
    end
  end

  always_comb begin
    state_d = dbg_mam_pkg::ARB_IDLE;
    case (state_q)
      dbg_mam_pkg::ARB_IDLE: begin
        // Debug side wins when both lock together
        if (biu_mam_hmastlock_i) begin
          state_d = dbg_mam_pkg::ARB_ACCESS_MAM;
        end else if (biu_in_hmastlock_i) begin
          state_d = dbg_mam_pkg::ARB_ACCESS_CPU;
        end
      end
      dbg_mam_pkg::ARB_ACCESS_MAM: begin
        if (biu_mam_hmastlock_i) begin
          state_d = dbg_mam_pkg::ARB_ACCESS_MAM;
        end
      end
      dbg_mam_pkg::ARB_ACCESS_CPU: begin
        // Locked CPU runs to the end, then MAM may follow directly
        if (biu_in_hmastlock_i) begin
          state_d = dbg_mam_pkg::ARB_ACCESS_CPU;
        end else if (biu_mam_hmastlock_i) begin
          state_d = dbg_mam_pkg::ARB_ACCESS_MAM;
        end
      end
      default: state_d = dbg_mam_pkg::ARB_IDLE;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Request mux to the memory
  //////////////////////////////////////////////////////////////////////

  assign biu_out_hsel_o      = access_cpu ? biu_in_hsel_i      : biu_mam_hsel_i;
  assign biu_out_haddr_o     = access_cpu ? biu_in_haddr_i     : biu_mam_haddr_i;
  assign biu_out_hwdata_o    = access_cpu ? biu_in_hwdata_i    : biu_mam_hwdata_i;
  assign biu_out_hwrite_o    = access_cpu ? biu_in_hwrite_i    : biu_mam_hwrite_i;
  assign biu_out_hsize_o     = access_cpu ? biu_in_hsize_i     : biu_mam_hsize_i;
  assign biu_out_htrans_o    = access_cpu ? biu_in_htrans_i    : biu_mam_htrans_i;
  assign biu_out_hmastlock_o = access_cpu ? biu_in_hmastlock_i : biu_mam_hmastlock_i;

  //////////////////////////////////////////////////////////////////////
  // Response steering
  //////////////////////////////////////////////////////////////////////

  // Side without the grant sees a stalled, quiet bus
  assign biu_in_hrdata_o  = access_cpu ? biu_out_hrdata_i : '0;
  assign biu_in_hready_o  = access_cpu & biu_out_hready_i;
  assign biu_in_hresp_o   = access_cpu & biu_out_hresp_i;

  assign biu_mam_hrdata_o = access_cpu ? '0 : biu_out_hrdata_i;
  assign biu_mam_hready_o = ~access_cpu & biu_out_hready_i;
  assign biu_mam_hresp_o  = ~access_cpu & biu_out_hresp_i;

endmodule

// File: dbg_mam_ahb_master.sv
//////////////////////////////////////////////////////////////////////
// One locked single-word transfer per command; mam_req_i is only
// taken while mam_busy_o is low
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dbg_mam_ahb_master (
  input  logic                          biu_in_clk_i,
  input  logic                          biu_in_rst_i,

  // Debug command port
  input  logic                          mam_req_i,
  input  dbg_mam_pkg::mam_op_e          mam_op_i,
  input  logic [dbg_mam_pkg::PLEN-1:0]  mam_addr_i,
  input  logic [dbg_mam_pkg::XLEN-1:0]  mam_wdata_i,
  output logic                          mam_busy_o,
  output logic                          mam_done_o,
  output logic [dbg_mam_pkg::XLEN-1:0]  mam_rdata_o,
  output logic                          mam_err_o,

  // AHB master side
  output logic                          biu_mam_hsel_o,
  output logic [dbg_mam_pkg::PLEN-1:0]  biu_mam_haddr_o,
  output logic [dbg_mam_pkg::XLEN-1:0]  biu_mam_hwdata_o,
  output logic                          biu_mam_hwrite_o,
  output logic [2:0]                    biu_mam_hsize_o,
  output logic [1:0]                    biu_mam_htrans_o,
  output logic                          biu_mam_hmastlock_o,
  input  logic [dbg_mam_pkg::XLEN-1:0]  biu_mam_hrdata_i,
  input  logic                          biu_mam_hready_i,
  input  logic                          biu_mam_hresp_i
);

  dbg_mam_pkg::mam_state_e state_q;

  // Grant wait count, two cycles in MAM_LOCK
  logic wait_q;
  logic err_q;

  // Captured command
  dbg_mam_pkg::mam_op_e            op_q;
  logic [dbg_mam_pkg::PLEN-1:0]    addr_q;
  logic [dbg_mam_pkg::XLEN-1:0]    wdata_q;
  logic [dbg_mam_pkg::XLEN-1:0]    rdata_q;

  always_ff @(posedge biu_in_clk_i) begin
    if (biu_in_rst_i) begin
      state_q <= dbg_mam_pkg::MAM_IDLE;
      wait_q  <= 1'b0;
      err_q   <= 1'b0;
    end else begin
      case (state_q)
        dbg_mam_pkg::MAM_IDLE: begin
          if (mam_req_i) begin
            state_q <= dbg_mam_pkg::MAM_LOCK;
            wait_q  <= 1'b0;
            err_q   <= 1'b0;
          end
        end
        dbg_mam_pkg::MAM_LOCK: begin
          // Arbiter needs two edges before the grant reaches the RAM
          wait_q <= 1'b1;
          if (wait_q) begin
            state_q <= dbg_mam_pkg::MAM_ADDR;
          end
        end
        dbg_mam_pkg::MAM_ADDR: begin
          // Held here while the CPU still owns the bus
          if (biu_mam_hready_i) begin
            state_q <= dbg_mam_pkg::MAM_DATA;
          end
        end
        dbg_mam_pkg::MAM_DATA: begin
          if (biu_mam_hready_i) begin
            err_q   <= biu_mam_hresp_i;
            state_q <= dbg_mam_pkg::MAM_RELEASE;
          end
        end
        default: state_q <= dbg_mam_pkg::MAM_IDLE;
      endcase
    end
  end

  // Command and read data capture
  always_ff @(posedge biu_in_clk_i) begin
    if (state_q == dbg_mam_pkg::MAM_IDLE && mam_req_i) begin
      op_q    <= mam_op_i;
      addr_q  <= mam_addr_i;
      wdata_q <= mam_wdata_i;
    end
    if (state_q == dbg_mam_pkg::MAM_DATA && biu_mam_hready_i) begin
      rdata_q <= biu_mam_hrdata_i;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Bus and command outputs
  //////////////////////////////////////////////////////////////////////

  assign biu_mam_hsel_o      = (state_q == dbg_mam_pkg::MAM_ADDR);
  assign biu_mam_htrans_o    = biu_mam_hsel_o ? dbg_mam_pkg::HTRANS_NONSEQ
                                              : dbg_mam_pkg::HTRANS_IDLE;
  assign biu_mam_haddr_o     = addr_q;
  assign biu_mam_hwrite_o    = (op_q == dbg_mam_pkg::MAM_OP_WRITE);
  assign biu_mam_hsize_o     = dbg_mam_pkg::HSIZE_WORD;
  // write data only in the data phase
  assign biu_mam_hwdata_o    = (state_q == dbg_mam_pkg::MAM_DATA) ? wdata_q : '0;
  assign biu_mam_hmastlock_o = (state_q == dbg_mam_pkg::MAM_LOCK) ||
                               (state_q == dbg_mam_pkg::MAM_ADDR) ||
                               (state_q == dbg_mam_pkg::MAM_DATA);

  assign mam_busy_o  = (state_q != dbg_mam_pkg::MAM_IDLE);
  // Done pulse comes one cycle after the data end, with the lock down
  assign mam_done_o  = (state_q == dbg_mam_pkg::MAM_RELEASE);
  assign mam_rdata_o = rdata_q;
  assign mam_err_o   = err_q;

endmodule

// File: dbg_mam_ahb_ram.sv
//////////////////////////////////////////////////////////////////////
// 256 words, word size only, one wait state; errors leave memory as is
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dbg_mam_ahb_ram (
  input  logic                          biu_in_clk_i,
  input  logic                          biu_in_rst_i,

  // Memory side request
  input  logic                          biu_out_hsel_i,
  input  logic [dbg_mam_pkg::PLEN-1:0]  biu_out_haddr_i,
  input  logic [dbg_mam_pkg::XLEN-1:0]  biu_out_hwdata_i,
  input  logic                          biu_out_hwrite_i,
  input  logic [2:0]                    biu_out_hsize_i,
  input  logic [1:0]                    biu_out_htrans_i,
  input  logic                          biu_out_hmastlock_i,

  // Response
  output logic [dbg_mam_pkg::XLEN-1:0]  biu_out_hrdata_o,
  output logic                          biu_out_hready_o,
  output logic                          biu_out_hresp_o
);

  logic [dbg_mam_pkg::XLEN-1:0] mem [2**dbg_mam_pkg::MEM_AW];

  logic                           accept;
  logic                           bad_addr;
  logic                           bad;

  // Data phase in progress (the wait state cycle)
  logic                           dphase_q;
  logic                           we_q;
  logic                           bad_q;
  logic [dbg_mam_pkg::MEM_AW-1:0] idx_q;

  // Only locked transfers count, the arbiter path is settled then
  assign accept = biu_out_hsel_i && biu_out_hmastlock_i && biu_out_hready_o &&
                  (biu_out_htrans_i == dbg_mam_pkg::HTRANS_NONSEQ);

  // Upper address bits beyond the word index must be zero
  assign bad_addr = |biu_out_haddr_i[dbg_mam_pkg::PLEN-1:dbg_mam_pkg::MEM_AW+2];
  assign bad      = bad_addr || (biu_out_hsize_i != dbg_mam_pkg::HSIZE_WORD);

  //////////////////////////////////////////////////////////////////////
  // Response sequencing
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge biu_in_clk_i) begin
    if (biu_in_rst_i) begin
      dphase_q         <= 1'b0;
      biu_out_hready_o <= 1'b1;
      biu_out_hresp_o  <= 1'b0;
    end else if (dphase_q) begin
      // End of wait state, second cycle of an error response
      dphase_q         <= 1'b0;
      biu_out_hready_o <= 1'b1;
      biu_out_hresp_o  <= bad_q;
    end else if (accept) begin
      // First cycle, hresp already up for an error
      dphase_q         <= 1'b1;
      biu_out_hready_o <= 1'b0;
      biu_out_hresp_o  <= bad;
    end else begin
      biu_out_hresp_o  <= 1'b0;
    end
  end

  // Address phase capture
  always_ff @(posedge biu_in_clk_i) begin
    if (accept) begin
      we_q  <= biu_out_hwrite_i;
      bad_q <= bad;
      idx_q <= biu_out_haddr_i[dbg_mam_pkg::MEM_AW+1:2];
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Storage
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge biu_in_clk_i) begin
    if (dphase_q) begin
      if (we_q && !bad_q) begin
        mem[idx_q] <= biu_out_hwdata_i;
      end
      // zero on error or write
      biu_out_hrdata_o <= (we_q || bad_q) ? '0 : mem[idx_q];
    end
  end

endmodule

// File: dbg_mam_subsys_top.sv
//////////////////////////////////////////////////////////////////////
// CPU port must lock the bus around its transfers like the MAM does
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module dbg_mam_subsys_top (
  input  logic                          biu_in_clk_i,
  input  logic                          biu_in_rst_i,

  // CPU bus port
  input  logic                          biu_in_hsel_i,
  input  logic [dbg_mam_pkg::PLEN-1:0]  biu_in_haddr_i,
  input  logic [dbg_mam_pkg::XLEN-1:0]  biu_in_hwdata_i,
  input  logic                          biu_in_hwrite_i,
  input  logic [2:0]                    biu_in_hsize_i,
  input  logic [1:0]                    biu_in_htrans_i,
  input  logic                          biu_in_hmastlock_i,
  output logic [dbg_mam_pkg::XLEN-1:0]  biu_in_hrdata_o,
  output logic                          biu_in_hready_o,
  output logic                          biu_in_hresp_o,

  // Debug command port
  input  logic                          mam_req_i,
  input  dbg_mam_pkg::mam_op_e          mam_op_i,
  input  logic [dbg_mam_pkg::PLEN-1:0]  mam_addr_i,
  input  logic [dbg_mam_pkg::XLEN-1:0]  mam_wdata_i,
  output logic                          mam_busy_o,
  output logic                          mam_done_o,
  output logic [dbg_mam_pkg::XLEN-1:0]  mam_rdata_o,
  output logic                          mam_err_o
);

  // MAM master bundle
  logic                          mam_hsel;
  logic [dbg_mam_pkg::PLEN-1:0]  mam_haddr;
  logic [dbg_mam_pkg::XLEN-1:0]  mam_hwdata;
  logic                          mam_hwrite;
  logic [2:0]                    mam_hsize;
  logic [1:0]                    mam_htrans;
  logic                          mam_hmastlock;
  logic [dbg_mam_pkg::XLEN-1:0]  mam_hrdata;
  logic                          mam_hready;
  logic                          mam_hresp;

  // Memory bundle
  logic                          out_hsel;
  logic [dbg_mam_pkg::PLEN-1:0]  out_haddr;
  logic [dbg_mam_pkg::XLEN-1:0]  out_hwdata;
  logic                          out_hwrite;
  logic [2:0]                    out_hsize;
  logic [1:0]                    out_htrans;
  logic                          out_hmastlock;
  logic [dbg_mam_pkg::XLEN-1:0]  out_hrdata;
  logic                          out_hready;
  logic                          out_hresp;

  // Debug command engine
  dbg_mam_ahb_master i_dbg_mam_ahb_master (
    .biu_in_clk_i        (biu_in_clk_i),
    .biu_in_rst_i        (biu_in_rst_i),
    .mam_req_i           (mam_req_i),
    .mam_op_i            (mam_op_i),
    .mam_addr_i          (mam_addr_i),
    .mam_wdata_i         (mam_wdata_i),
    .mam_busy_o          (mam_busy_o),
    .mam_done_o          (mam_done_o),
    .mam_rdata_o         (mam_rdata_o),
    .mam_err_o           (mam_err_o),
    .biu_mam_hsel_o      (mam_hsel),
    .biu_mam_haddr_o     (mam_haddr),
    .biu_mam_hwdata_o    (mam_hwdata),
    .biu_mam_hwrite_o    (mam_hwrite),
    .biu_mam_hsize_o     (mam_hsize),
    .biu_mam_htrans_o    (mam_htrans),
    .biu_mam_hmastlock_o (mam_hmastlock),
    .biu_mam_hrdata_i    (mam_hrdata),
    .biu_mam_hready_i    (mam_hready),
    .biu_mam_hresp_i     (mam_hresp)
  );

  // Two masters onto one RAM
  dbg_mam_ahb_arbiter i_dbg_mam_ahb_arbiter (
    .biu_in_clk_i        (biu_in_clk_i),
    .biu_in_rst_i        (biu_in_rst_i),
    .biu_in_hsel_i       (biu_in_hsel_i),
    .biu_in_haddr_i      (biu_in_haddr_i),
    .biu_in_hwdata_i     (biu_in_hwdata_i),
    .biu_in_hwrite_i     (biu_in_hwrite_i),
    .biu_in_hsize_i      (biu_in_hsize_i),
    .biu_in_htrans_i     (biu_in_htrans_i),
    .biu_in_hmastlock_i  (biu_in_hmastlock_i),
    .biu_in_hrdata_o     (biu_in_hrdata_o),
    .biu_in_hready_o     (biu_in_hready_o),
    .biu_in_hresp_o      (biu_in_hresp_o),
    .biu_mam_hsel_i      (mam_hsel),
    .biu_mam_haddr_i     (mam_haddr),
    .biu_mam_hwdata_i    (mam_hwdata),
    .biu_mam_hwrite_i    (mam_hwrite),
    .biu_mam_hsize_i     (mam_hsize),
    .biu_mam_htrans_i    (mam_htrans),
    .biu_mam_hmastlock_i (mam_hmastlock),
    .biu_mam_hrdata_o    (mam_hrdata),
    .biu_mam_hready_o    (mam_hready),
    .biu_mam_hresp_o     (mam_hresp),
    .biu_out_hsel_o      (out_hsel),
    .biu_out_haddr_o     (out_haddr),
    .biu_out_hwdata_o    (out_hwdata),
    .biu_out_hwrite_o    (out_hwrite),
    .biu_out_hsize_o     (out_hsize),
    .biu_out_htrans_o    (out_htrans),
    .biu_out_hmastlock_o (out_hmastlock),
    .biu_out_hrdata_i    (out_hrdata),
    .biu_out_hready_i    (out_hready),
    .biu_out_hresp_i     (out_hresp)
  );

  // Shared on-chip RAM
  dbg_mam_ahb_ram i_dbg_mam_ahb_ram (
    .biu_in_clk_i        (biu_in_clk_i),
    .biu_in_rst_i        (biu_in_rst_i),
    .biu_out_hsel_i      (out_hsel),
    .biu_out_haddr_i     (out_haddr),
    .biu_out_hwdata_i    (out_hwdata),
    .biu_out_hwrite_i    (out_hwrite),
    .biu_out_hsize_i     (out_hsize),
    .biu_out_htrans_i    (out_htrans),
    .biu_out_hmastlock_i (out_hmastlock),
    .biu_out_hrdata_o    (out_hrdata),
    .biu_out_hready_o    (out_hready),
    .biu_out_hresp_o     (out_hresp)
  );

endmodule

// File: tb_dbg_mam_subsys.sv
//////////////////////////////////////////////////////////////////////
// Stim file is opened from the working directory; RAM words read back
// must have been written earlier in the stim, the RAM has no reset
//////////////////////////////////////////////////////////////////////
`timescale 1ns/10ps

module tb_dbg_mam_subsys;

  logic                          clk;
  logic                          rst;

  // CPU bus port
  logic                          cpu_hsel;
  logic [dbg_mam_pkg::PLEN-1:0]  cpu_haddr;
  logic [dbg_mam_pkg::XLEN-1:0]  cpu_hwdata;
  logic                          cpu_hwrite;
  logic [2:0]                    cpu_hsize;
  logic [1:0]                    cpu_htrans;
  logic                          cpu_hmastlock;
  logic [dbg_mam_pkg::XLEN-1:0]  cpu_hrdata;
  logic                          cpu_hready;
  logic                          cpu_hresp;

  // Debug command port
  logic                          mam_req;
  dbg_mam_pkg::mam_op_e          mam_op;
  logic [dbg_mam_pkg::PLEN-1:0]  mam_addr;
  logic [dbg_mam_pkg::XLEN-1:0]  mam_wdata;
  logic                          mam_busy;
  logic                          mam_done;
  logic [dbg_mam_pkg::XLEN-1:0]  mam_rdata;
  logic                          mam_err;

  // Stim table, one entry per operation
  string       src_q[$];
  string       op_q[$];
  logic [31:0] addr_q[$];
  logic [31:0] data_q[$];
  logic [31:0] exp_q[$];
  logic [31:0] err_q[$];

  int     errors;
  int     checks;
  int     n_ops;
  int     gap;
  integer seed;
  logic   stim_loaded;

  dbg_mam_subsys_top i_dbg_mam_subsys_top (
    .biu_in_clk_i       (clk),
    .biu_in_rst_i       (rst),
    .biu_in_hsel_i      (cpu_hsel),
    .biu_in_haddr_i     (cpu_haddr),
    .biu_in_hwdata_i    (cpu_hwdata),
    .biu_in_hwrite_i    (cpu_hwrite),
    .biu_in_hsize_i     (cpu_hsize),
    .biu_in_htrans_i    (cpu_htrans),
    .biu_in_hmastlock_i (cpu_hmastlock),
    .biu_in_hrdata_o    (cpu_hrdata),
    .biu_in_hready_o    (cpu_hready),
    .biu_in_hresp_o     (cpu_hresp),
    .mam_req_i          (mam_req),
    .mam_op_i           (mam_op),
    .mam_addr_i         (mam_addr),
    .mam_wdata_i        (mam_wdata),
    .mam_busy_o         (mam_busy),
    .mam_done_o         (mam_done),
    .mam_rdata_o        (mam_rdata),
    .mam_err_o          (mam_err)
  );

  // 10 ns clock
  initial begin
    clk = 1'b0;
    forever #5 clk = ~clk;
  end

  //////////////////////////////////////////////////////////////////////
  // Helpers
  //////////////////////////////////////////////////////////////////////

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[FAIL] %0d ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic load_stim();
    int                fd;
    int                r;
    string             tok;
    string             op;
    logic [8*200-1:0]  rest;
    logic [31:0]       a;
    logic [31:0]       d;
    logic [31:0]       e;
    logic [31:0]       er;
    logic              eof;
    fd = $fopen("dbg_mam_subsys_stim.txt", "r");
    if (fd == 0) begin
      $display("Could not open the stim file dbg_mam_subsys_stim.txt");
      errors++;
    end else begin
      eof = 1'b0;
      while (!eof) begin
        r = $fscanf(fd, "%s", tok);
        if (r != 1) begin
          eof = 1'b1;
        end else if (tok == "#") begin
          // Rest of a comment line
          r = $fgets(rest, fd);
        end else begin
          r = $fscanf(fd, "%s %h %h %h %h", op, a, d, e, er);
          if (r != 5) begin
            $display("Stim line starting with %s is incomplete", tok);
            errors++;
            eof = 1'b1;
          end else begin
            src_q.push_back(tok);
            op_q.push_back(op);
            addr_q.push_back(a);
            data_q.push_back(d);
            exp_q.push_back(e);
            err_q.push_back(er);
          end
        end
      end
      $fclose(fd);
    end
    n_ops = src_q.size();
  endtask

  //////////////////////////////////////////////////////////////////////
  // Bus drivers, all changes on the falling edge
  //////////////////////////////////////////////////////////////////////

  // Lock, then two cycles until the grant reaches the RAM
  task automatic cpu_lock();
    cpu_hmastlock = 1'b1;
    repeat (2) @(negedge clk);
  endtask

  // Lock held past the data end
  task automatic cpu_unlock();
    @(negedge clk);
    cpu_hmastlock = 1'b0;
  endtask

  task automatic cpu_xfer(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                          input logic [2:0] size, output logic [31:0] rdata,
                          output logic err);
    // Address phase, held while the arbiter stalls
    cpu_hsel   = 1'b1;
    cpu_htrans = dbg_mam_pkg::HTRANS_NONSEQ;
    cpu_haddr  = addr;
    cpu_hwrite = wr;
    cpu_hsize  = size;
    while (!cpu_hready) @(negedge clk);
    @(negedge clk);
    // Data phase
    cpu_hsel   = 1'b0;
    cpu_htrans = dbg_mam_pkg::HTRANS_IDLE;
    cpu_hwdata = wr ? wdata : '0;
    while (!cpu_hready) @(negedge clk);
    rdata = cpu_hrdata;
    err   = cpu_hresp;
  endtask

  task automatic mam_cmd(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                         output logic [31:0] rdata, output logic err, output time t_done);
    while (mam_busy) @(negedge clk);
    mam_req   = 1'b1;
    mam_addr  = addr;
    mam_wdata = wdata;
    if (wr) begin
      mam_op = dbg_mam_pkg::MAM_OP_WRITE;
    end else begin
      mam_op = dbg_mam_pkg::MAM_OP_READ;
    end
    @(negedge clk);
    mam_req = 1'b0;
    while (!mam_done) @(negedge clk);
    rdata  = mam_rdata;
    err    = mam_err;
    t_done = $time;
  endtask

  //////////////////////////////////////////////////////////////////////
  // One stim operation
  //////////////////////////////////////////////////////////////////////

  task automatic run_op(input int i);
    logic [31:0] c_rdata;
    logic [31:0] m_rdata;
    logic [31:0] w_rdata;
    logic        c_err;
    logic        w_err;
    logic        m_err;
    logic        wr;
    logic [2:0]  size;
    time         t_mam;
    time         t_cpu;
    string       tag;
    tag  = $sformatf("op %0d %s %s %h", i, src_q[i], op_q[i], addr_q[i]);
    wr   = (op_q[i] != "R");
    size = (op_q[i] == "B") ? 3'b000 : dbg_mam_pkg::HSIZE_WORD;
    while (mam_busy) @(negedge clk);
    if (src_q[i] == "CPU") begin
      cpu_lock();
      cpu_xfer(wr, addr_q[i], data_q[i], size, c_rdata, c_err);
      cpu_unlock();
      check(32'(c_err), err_q[i], {tag, " CPU hresp"});
      if (!wr) begin
        check(c_rdata, exp_q[i], {tag, " CPU hrdata"});
      end
    end else if (src_q[i] == "MAM") begin
      mam_cmd(wr, addr_q[i], data_q[i], m_rdata, m_err, t_mam);
      check(32'(m_err), err_q[i], {tag, " mam_err"});
      if (!wr) begin
        check(m_rdata, exp_q[i], {tag, " mam_rdata"});
      end
    end else if (src_q[i] == "BOTH") begin
      // MAM lock shows one cycle after the strobe, CPU locks in that cycle
      fork
        mam_cmd(1'b1, addr_q[i], data_q[i], m_rdata, m_err, t_mam);
        begin
          @(negedge clk);
          cpu_lock();
          cpu_xfer(1'b1, addr_q[i], exp_q[i], size, c_rdata, c_err);
          t_cpu = $time;
          cpu_unlock();
        end
      join
      check(32'(m_err), err_q[i], {tag, " mam_err"});
      check(32'(c_err), err_q[i], {tag, " CPU hresp"});
      check(32'(t_mam < t_cpu), 32'd1, {tag, " MAM done before CPU data end"});
    end else if (src_q[i] == "HOLD") begin
      // CPU keeps the bus over two transfers, MAM read waits behind it
      cpu_lock();
      fork
        begin
          cpu_xfer(1'b1, addr_q[i], data_q[i], size, w_rdata, w_err);
          cpu_xfer(1'b0, addr_q[i], '0, size, c_rdata, c_err);
          cpu_unlock();
          t_cpu = $time;
        end
        mam_cmd(1'b0, addr_q[i], '0, m_rdata, m_err, t_mam);
      join
      check(32'(w_err | c_err), err_q[i], {tag, " CPU hresp"});
      check(c_rdata, data_q[i], {tag, " CPU read back"});
      check(32'(m_err), err_q[i], {tag, " mam_err"});
      check(m_rdata, exp_q[i], {tag, " mam_rdata"});
      check(32'(t_mam > t_cpu), 32'd1, {tag, " MAM done after CPU lock fell"});
    end else begin
      $display("Unknown source %s in stim operation %0d", src_q[i], i);
      errors++;
    end
  endtask

  //////////////////////////////////////////////////////////////////////
  // Main sequence
  //////////////////////////////////////////////////////////////////////

  initial begin
    rst           = 1'b1;
    cpu_hsel      = 1'b0;
    cpu_haddr     = '0;
    cpu_hwdata    = '0;
    cpu_hwrite    = 1'b0;
    cpu_hsize     = dbg_mam_pkg::HSIZE_WORD;
    cpu_htrans    = dbg_mam_pkg::HTRANS_IDLE;
    cpu_hmastlock = 1'b0;
    mam_req       = 1'b0;
    mam_op        = dbg_mam_pkg::MAM_OP_READ;
    mam_addr      = '0;
    mam_wdata     = '0;
    errors        = 0;
    checks        = 0;
    seed          = 88;
    stim_loaded   = 1'b0;
    load_stim();
    stim_loaded = 1'b1;
    repeat (4) @(negedge clk);
    rst = 1'b0;
    // Quiet outputs straight after reset
    check(32'(cpu_hready), 32'd0, "hready after reset");
    check(32'(mam_busy), 32'd0, "mam_busy after reset");
    check(32'(mam_done), 32'd0, "mam_done after reset");
    check(32'(mam_err), 32'd0, "mam_err after reset");
    for (int i = 0; i < n_ops; i++) begin
      run_op(i);
      gap = $unsigned($random(seed)) % 4;
      repeat (gap) @(negedge clk);
    end
    repeat (4) @(negedge clk);
    $display("Summary: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

  // Watchdog, 40 cycles per operation plus reset margin
  initial begin
    wait (stim_loaded);
    repeat ((n_ops + 1) * 40) @(posedge clk);
    $display("Timeout: operations did not finish within %0d cycles", (n_ops + 1) * 40);
    $display("TEST FAIL");
    $finish;
  end

endmodule

// File: dbg_mam_subsys_stim.txt
# src op addr data exp_rdata exp_err; addr and data columns are hex; op R read, W write, B byte write
# BOTH: MAM writes data, CPU writes exp_rdata; HOLD: locked CPU writes data and reads back, MAM reads
CPU  W 00000000 11111111 00000000 0
CPU  R 00000000 00000000 11111111 0
MAM  W 00000004 22222222 00000000 0
MAM  R 00000004 00000000 22222222 0
MAM  W 00000008 33333333 00000000 0
CPU  R 00000008 00000000 33333333 0
CPU  W 0000000c 44444444 00000000 0
MAM  R 0000000c 00000000 44444444 0
CPU  W 000003fc 5a5a5a5a 00000000 0
MAM  R 000003fc 00000000 5a5a5a5a 0
BOTH W 00000020 aaaa0000 bbbb0000 0
CPU  R 00000020 00000000 bbbb0000 0
MAM  R 00000020 00000000 bbbb0000 0
BOTH W 00000024 c0c0c0c0 0d0d0d0d 0
MAM  R 00000024 00000000 0d0d0d0d 0
HOLD W 00000030 5555aaaa 5555aaaa 0
MAM  R 00000030 00000000 5555aaaa 0
HOLD W 00000034 76543210 76543210 0
# Error cases, target words keep their old contents
MAM  W 00000400 deadbeef 00000000 1
CPU  R 00000000 00000000 11111111 0
CPU  W 00000404 deadbeef 00000000 1
MAM  R 00000004 00000000 22222222 0
MAM  R 80000000 00000000 00000000 1
CPU  R 00000800 00000000 00000000 1
CPU  W 00000010 0f0f0f0f 00000000 0
CPU  B 00000010 ffffffff 00000000 1
CPU  R 00000010 00000000 0f0f0f0f 0
MAM  R 00000010 00000000 0f0f0f0f 0

// File: dbg_mam_subsys_top.f
dbg_mam_pkg.sv
dbg_mam_ahb_arbiter.sv
dbg_mam_ahb_master.sv
dbg_mam_ahb_ram.sv
dbg_mam_subsys_top.sv
tb_dbg_mam_subsys.sv

// File: run_sim.sh
#!/bin/sh
# Build and run the testbench with Verilator from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/10ps \
  --top-module tb_dbg_mam_subsys \
  -f dbg_mam_subsys_top.f \
  -o tb_dbg_mam_subsys

out=$(./obj_dir/tb_dbg_mam_subsys)
echo "$out"

if echo "$out" | grep -qx "TEST PASS"; then
  exit 0
fi
exit 1
